//--- Makefile
# Verilator flow for the pext_alu packed-SIMD ALU and its testbench

VERILATOR ?= verilator
TOP       := pext_alu_tb
RTL_TOP   := pext_alu
FILELIST  := pext_alu.f
RTL_SRCS  := $(shell grep '^src/' $(FILELIST))
BUILD_DIR := obj_dir
LOG       := sim.log
FLAGS     := --timing --assert
SIM_FLAGS := $(FLAGS) --binary -j 0
PASS_TEXT := TEST PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) $(RTL_SRCS) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_TEXT)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- pext_alu.f
+incdir+tb
src/pext_pkg.sv
src/pext_decoder.sv
src/pext_byte_lane.sv
src/pext_result_unit.sv
src/pext_alu.sv
tb/pext_alu_tb.sv

//--- src/pext_alu.sv
// Packed-SIMD ALU top, one cycle from request to result
// A new request may be issued every cycle, there is no back-pressure

`timescale 1ns/10ps

module pext_alu (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      enable_i,
  input  pext_pkg::pext_req_t       req_i,
  output logic [pext_pkg::XLEN-1:0] result_o,
  output logic                      valid_o
);
  import pext_pkg::*;

  lane_ctrl_t                       lane_ctrl;
  logic [NUM_LANES-1:0][LANE_W-1:0] a_lane;
  logic [NUM_LANES-1:0][LANE_W-1:0] b_lane;
  logic [NUM_LANES-1:0]             join_bits;
  logic [NUM_LANES-1:0]             carry_in;
  logic [NUM_LANES-1:0]             carry_out;
  lane_res_t [NUM_LANES-1:0]        lane_res;

  pext_decoder u_decoder (
    .req_i       (req_i),
    .lane_ctrl_o (lane_ctrl),
    .a_lane_o    (a_lane),
    .b_lane_o    (b_lane),
    .join_o      (join_bits)
  );

  // Lane 0 never joins, its chained carry is a dummy
  assign carry_in = {carry_out[NUM_LANES-2:0], 1'b0};

  for (genvar k = 0; k < NUM_LANES; k++) begin : gen_lane
    pext_byte_lane u_lane (
      .a_i     (a_lane[k]),
      .b_i     (b_lane[k]),
      .ctrl_i  (lane_ctrl),
      .join_i  (join_bits[k]),
      .carry_i (carry_in[k]),
      .carry_o (carry_out[k]),
      .res_o   (lane_res[k])
    );
  end

  pext_result_unit u_result (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .enable_i (enable_i),
    .req_i    (req_i),
    .lanes_i  (lane_res),
    .result_o (result_o),
    .valid_o  (valid_o)
  );

endmodule

//--- src/pext_byte_lane.sv
// One 8-bit slice of the packed adder, purely combinational
// ext_top extends the sum by one bit so that halving and saturation see the
// exact result; for a joined lane it covers the whole halfword

`timescale 1ns/10ps

module pext_byte_lane (
  input  logic [pext_pkg::LANE_W-1:0] a_i,
  input  logic [pext_pkg::LANE_W-1:0] b_i,
  input  pext_pkg::lane_ctrl_t        ctrl_i,
  input  logic                        join_i,
  input  logic                        carry_i,
  output logic                        carry_o,
  output pext_pkg::lane_res_t         res_o
);
  import pext_pkg::*;

  logic [LANE_W-1:0] b_eff;
  logic              cin;
  logic [LANE_W:0]   sum_full;
  logic              ext_top;

  // Two's complement subtract as a + ~b + 1
  assign b_eff = ctrl_i.sub ? ~b_i : b_i;

  // Joined lane continues the lower byte, otherwise start fresh
  assign cin = join_i ? carry_i : ctrl_i.sub;

  assign sum_full = {1'b0, a_i} + {1'b0, b_eff} + {{LANE_W{1'b0}}, cin};
  assign carry_o  = sum_full[LANE_W];

  //////////////////////////////
  // Extended top bit
  //////////////////////////////

  always_comb begin
    if (ctrl_i.is_signed) begin
      // Sign-extended operands, so bit 8 is a7 ^ b7 ^ carry
      ext_top = a_i[LANE_W-1] ^ b_eff[LANE_W-1] ^ sum_full[LANE_W];
    end else if (ctrl_i.sub) begin
      // No carry out means a < b, the difference is negative
      ext_top = ~sum_full[LANE_W];
    end else begin
      ext_top = sum_full[LANE_W];
    end
  end

  assign res_o.sum     = sum_full[LANE_W-1:0];
  assign res_o.ext_top = ext_top;
  assign res_o.zero    = (sum_full[LANE_W-1:0] == '0);

endmodule

//--- src/pext_decoder.sv
// Combinational request decode for the byte lanes
// Lanes 1 and 3 take the chained carry only for halfword elements

`timescale 1ns/10ps

module pext_decoder (
  input  pext_pkg::pext_req_t                                  req_i,
  output pext_pkg::lane_ctrl_t                                 lane_ctrl_o,
  output logic [pext_pkg::NUM_LANES-1:0][pext_pkg::LANE_W-1:0] a_lane_o,
  output logic [pext_pkg::NUM_LANES-1:0][pext_pkg::LANE_W-1:0] b_lane_o,
  output logic [pext_pkg::NUM_LANES-1:0]                       join_o
);
  import pext_pkg::*;

  logic sub;
  logic is_signed;
  logic half;

  //////////////////////////////
  // Adder direction
  //////////////////////////////

  // Compares and min/max look at a - b
  always_comb begin
    unique case (req_i.op)
      OP_SUB, OP_HSUB, OP_SSUB,
      OP_CMPEQ, OP_CMPLT, OP_CMPLE,
      OP_MIN, OP_MAX: sub = 1'b1;
      default:        sub = 1'b0;
    endcase
  end

  //////////////////////////////
  // Element type
  //////////////////////////////

  always_comb begin
    unique case (req_i.elem)
      ELEM_S8: begin
        is_signed = 1'b1;
        half      = 1'b0;
      end
      ELEM_U16: begin
        is_signed = 1'b0;
        half      = 1'b1;
      end
      ELEM_S16: begin
        is_signed = 1'b1;
        half      = 1'b1;
      end
      default: begin
        is_signed = 1'b0;
        half      = 1'b0;
      end
    endcase
  end

  assign lane_ctrl_o.sub       = sub;
  assign lane_ctrl_o.is_signed = is_signed;

  //////////////////////////////
  // Operand split
  //////////////////////////////

  for (genvar k = 0; k < NUM_LANES; k++) begin : gen_split
    assign a_lane_o[k] = req_i.a[k*LANE_W +: LANE_W];
    assign b_lane_o[k] = req_i.b[k*LANE_W +: LANE_W];

    // Odd lanes are the upper byte of a halfword
    assign join_o[k] = half && (k % 2 == 1);
  end

endmodule

//--- src/pext_pkg.sv
// Shared widths, saturation limits, opcodes and bundles of the packed-SIMD ALU
// Elements are four bytes or two halfwords of a 32-bit word
// A request carries both operands in full, so it is wider than a data word

package pext_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  localparam int XLEN      = 32;
  localparam int LANE_W    = 8;
  localparam int NUM_LANES = XLEN / LANE_W;

  //////////////////////////////
  // Saturation limits
  //////////////////////////////

  // Unsigned byte ceiling, a halfword ceiling is two of these
  localparam logic [LANE_W-1:0] SAT_U_MAX = 8'hff;

  // Signed byte limits
  localparam logic [LANE_W-1:0] SAT_S8_MIN = 8'h80;
  localparam logic [LANE_W-1:0] SAT_S8_MAX = 8'h7f;

  // Signed halfword limits
  localparam logic [2*LANE_W-1:0] SAT_S16_MIN = 16'h8000;
  localparam logic [2*LANE_W-1:0] SAT_S16_MAX = 16'h7fff;

  //////////////////////////////
  // Encodings
  //////////////////////////////

  // Operation family, width and signedness come from pext_elem_e
  typedef enum logic [3:0] {
    OP_ADD   = 4'd0,
    OP_HADD  = 4'd1,
    OP_SADD  = 4'd2,
    OP_SUB   = 4'd3,
    OP_HSUB  = 4'd4,
    OP_SSUB  = 4'd5,
    OP_CMPEQ = 4'd6,
    OP_CMPLT = 4'd7,
    OP_CMPLE = 4'd8,
    OP_MIN   = 4'd9,
    OP_MAX   = 4'd10
  } pext_op_e;

  // Bit 1 selects halfwords, bit 0 selects signed
  typedef enum logic [1:0] {
    ELEM_U8  = 2'b00,
    ELEM_S8  = 2'b01,
    ELEM_U16 = 2'b10,
    ELEM_S16 = 2'b11
  } pext_elem_e;

  //////////////////////////////
  // Bundles
  //////////////////////////////

  typedef struct packed {
    pext_op_e          op;
    pext_elem_e        elem;
    logic [XLEN-1:0]   a;
    logic [XLEN-1:0]   b;
  } pext_req_t;

  // Common to every lane
  typedef struct packed {
    logic sub;        // Invert b and add one
    logic is_signed;  // Elements are two's complement
  } lane_ctrl_t;

  // What a lane hands to the result stage
  typedef struct packed {
    logic [LANE_W-1:0] sum;
    logic              ext_top;  // Bit above the sum in the exact result
    logic              zero;     // Sum is all zero
  } lane_res_t;

endpackage

//--- src/pext_result_unit.sv
// Result formation and the single output register
// For halfwords the upper lane's flags describe the element
// enable_i low clears the registered word on the next edge

`timescale 1ns/10ps

module pext_result_unit (
  input  logic                                       clk_i,
  input  logic                                       reset_i,
  input  logic                                       enable_i,
  input  pext_pkg::pext_req_t                        req_i,
  input  pext_pkg::lane_res_t [pext_pkg::NUM_LANES-1:0] lanes_i,
  output logic [pext_pkg::XLEN-1:0]                  result_o,
  output logic                                       valid_o
);
  import pext_pkg::*;

  localparam int NUM_HALVES = NUM_LANES / 2;
  localparam int HALF_W     = 2 * LANE_W;

  logic                 half_sel;
  logic                 is_signed;
  logic                 sat_sub;

  logic [XLEN-1:0]      normal_res;
  logic [XLEN-1:0]      hadd8_res, hadd16_res;
  logic [XLEN-1:0]      sat8_res, sat16_res;
  logic [XLEN-1:0]      cmp_res;
  logic [XLEN-1:0]      minmax_res;
  logic [XLEN-1:0]      result_d;

  logic [NUM_LANES-1:0] eq_w;
  logic [NUM_LANES-1:0] lt_w;
  logic [NUM_LANES-1:0] cmp_flag;

  assign half_sel  = (req_i.elem == ELEM_U16) || (req_i.elem == ELEM_S16);
  assign is_signed = (req_i.elem == ELEM_S8) || (req_i.elem == ELEM_S16);
  assign sat_sub   = (req_i.op == OP_SSUB);

  //////////////////////////////
  // Byte elements
  //////////////////////////////

  for (genvar k = 0; k < NUM_LANES; k++) begin : gen_byte_elem
    logic              ext;
    logic              ovf;
    logic [LANE_W-1:0] sat_val;

    assign ext = lanes_i[k].ext_top;
    assign ovf = is_signed ? (ext ^ lanes_i[k].sum[LANE_W-1]) : ext;

    // Unsigned subtract can only fall below zero
    assign sat_val = is_signed ? (ext ? SAT_S8_MIN : SAT_S8_MAX) :
                                 (sat_sub ? '0 : SAT_U_MAX);

    assign normal_res[k*LANE_W +: LANE_W] = lanes_i[k].sum;
    assign hadd8_res[k*LANE_W +: LANE_W]  = {ext, lanes_i[k].sum[LANE_W-1:1]};
    assign sat8_res[k*LANE_W +: LANE_W]   = ovf ? sat_val : lanes_i[k].sum;
  end

  //////////////////////////////
  // Halfword elements
  //////////////////////////////

  for (genvar h = 0; h < NUM_HALVES; h++) begin : gen_half_elem
    lane_res_t         lo;
    lane_res_t         hi;
    logic              ovf;
    logic [HALF_W-1:0] sat_val;

    assign lo = lanes_i[2*h];
    assign hi = lanes_i[2*h+1];

    assign ovf = is_signed ? (hi.ext_top ^ hi.sum[LANE_W-1]) : hi.ext_top;
    assign sat_val = is_signed ? (hi.ext_top ? SAT_S16_MIN : SAT_S16_MAX) :
                                 (sat_sub ? '0 : {SAT_U_MAX, SAT_U_MAX});

    // 17-bit exact result shifted right by one
    assign hadd16_res[h*HALF_W +: HALF_W] = {hi.ext_top, hi.sum, lo.sum[LANE_W-1:1]};
    assign sat16_res[h*HALF_W +: HALF_W]  = ovf ? sat_val : {hi.sum, lo.sum};
  end

  //////////////////////////////
  // Compare and min/max
  //////////////////////////////

  for (genvar k = 0; k < NUM_LANES; k++) begin : gen_flags
    // Both bytes of a halfword share the flags of its element
    assign eq_w[k] = half_sel ? (lanes_i[k & ~1].zero & lanes_i[k | 1].zero) :
                                lanes_i[k].zero;
    assign lt_w[k] = half_sel ? lanes_i[k | 1].ext_top : lanes_i[k].ext_top;

    assign cmp_res[k*LANE_W +: LANE_W] = {LANE_W{cmp_flag[k]}};

    // Equal operands give the same value either way
    assign minmax_res[k*LANE_W +: LANE_W] =
      ((req_i.op == OP_MIN) ? lt_w[k] : ~lt_w[k]) ? req_i.a[k*LANE_W +: LANE_W] :
                                                     req_i.b[k*LANE_W +: LANE_W];
  end

  always_comb begin
    unique case (req_i.op)
      OP_CMPLT: cmp_flag = lt_w;
      OP_CMPLE: cmp_flag = lt_w | eq_w;
      default:  cmp_flag = eq_w;
    endcase
  end

  //////////////////////////////
  // Family select and register
  //////////////////////////////

  always_comb begin
    unique case (req_i.op)
      OP_HADD, OP_HSUB:             result_d = half_sel ? hadd16_res : hadd8_res;
      OP_SADD, OP_SSUB:             result_d = half_sel ? sat16_res : sat8_res;
      OP_CMPEQ, OP_CMPLT, OP_CMPLE: result_d = cmp_res;
      OP_MIN, OP_MAX:               result_d = minmax_res;
      default:                      result_d = normal_res;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      result_o <= '0;
      valid_o  <= 1'b0;
    end else begin
      result_o <= enable_i ? result_d : '0;
      valid_o  <= enable_i;
    end
  end

endmodule

//--- tb/pext_model.svh
// Expected word of one pext_alu request, worked element by element in integers
// Needs pext_pkg imported in the scope that includes it
// Op codes above OP_MAX are not modelled and give zero

`ifndef PEXT_MODEL_SVH
`define PEXT_MODEL_SVH

// Element e of a word, sign-extended when the type is signed
function automatic int elem_value(input logic [XLEN-1:0] word, input int e, input int w,
                                  input bit sgn);
  int v;
  v = int'((word >> (e * w)) & ((1 << w) - 1));
  if (sgn && v >= (1 << (w - 1))) begin
    v = v - (1 << w);
  end
  return v;
endfunction

function automatic int clamp_range(input int v, input int lo, input int hi);
  if (v > hi) begin
    return hi;
  end
  if (v < lo) begin
    return lo;
  end
  return v;
endfunction

function automatic logic [XLEN-1:0] pext_model(input pext_op_e op, input pext_elem_e elem,
                                               input logic [XLEN-1:0] a,
                                               input logic [XLEN-1:0] b);
  int              w;
  int              lo;
  int              hi;
  int              ea;
  int              eb;
  int              r;
  int              e;
  bit              sgn;
  logic [XLEN-1:0] bits;
  logic [XLEN-1:0] res;

  w   = (elem == ELEM_U16 || elem == ELEM_S16) ? 16 : 8;
  sgn = (elem == ELEM_S8 || elem == ELEM_S16);
  lo  = sgn ? -(1 << (w - 1)) : 0;
  hi  = sgn ? (1 << (w - 1)) - 1 : (1 << w) - 1;
  res = '0;
  for (e = 0; e < XLEN / w; e++) begin
    ea = elem_value(a, e, w, sgn);
    eb = elem_value(b, e, w, sgn);
    case (op)
      OP_ADD:   r = ea + eb;
      OP_SUB:   r = ea - eb;
      // Arithmetic shift of the exact value, so floor of half
      OP_HADD:  r = (ea + eb) >>> 1;
      OP_HSUB:  r = (ea - eb) >>> 1;
      OP_SADD:  r = clamp_range(ea + eb, lo, hi);
      OP_SSUB:  r = clamp_range(ea - eb, lo, hi);
      OP_CMPEQ: r = (ea == eb) ? -1 : 0;
      OP_CMPLT: r = (ea < eb) ? -1 : 0;
      OP_CMPLE: r = (ea <= eb) ? -1 : 0;
      OP_MIN:   r = (ea < eb) ? ea : eb;
      OP_MAX:   r = (ea > eb) ? ea : eb;
      default:  r = 0;
    endcase
    bits = r;
    bits = bits & ((1 << w) - 1);
    res  = res | (bits << (e * w));
  end
  return res;
endfunction

`endif

//--- tb/pext_alu_tb.sv
// Drives pext_alu and expects each result exactly one cycle after its request
// Directed table first, then random back-to-back requests over all families

`timescale 1ns/10ps

module pext_alu_tb;
  import pext_pkg::*;

  `include "pext_model.svh"

  localparam int RESET_CYCLES = 10;
  localparam int NUM_VEC      = 26;
  localparam int NUM_RANDOM   = 400;
  // Two idle cycles frame the random phase
  localparam int CYCLE_LIMIT  = 2 * (NUM_VEC + NUM_RANDOM + 2) + RESET_CYCLES;

  //////////////////////////////
  // Directed vectors
  //////////////////////////////

  localparam pext_req_t VEC_TABLE [NUM_VEC] = '{
    '{OP_ADD,   ELEM_U8,  32'h01ff_80ff, 32'h0101_8001},  // byte 0 carry stays put
    '{OP_ADD,   ELEM_U16, 32'h01ff_80ff, 32'h0101_8001},  // same carry joins byte 1
    '{OP_ADD,   ELEM_S16, 32'h00ff_7fff, 32'h0001_0001},
    '{OP_SUB,   ELEM_U8,  32'h0000_1000, 32'h0001_0001},
    '{OP_SUB,   ELEM_U16, 32'h0000_1000, 32'h0001_0001},
    '{OP_SUB,   ELEM_S8,  32'h8000_7f01, 32'h0180_ff02},
    '{OP_HADD,  ELEM_U8,  32'hff01_80ff, 32'hff02_80ff},
    '{OP_HADD,  ELEM_S16, 32'h8000_7fff, 32'h8000_7fff},
    '{OP_HADD,  ELEM_S8,  32'h8081_7f01, 32'h80ff_7f00},
    '{OP_HSUB,  ELEM_U16, 32'h0000_ffff, 32'hffff_0000},
    '{OP_HSUB,  ELEM_S8,  32'h807f_0103, 32'h7f80_0201},
    '{OP_SADD,  ELEM_U8,  32'hff80_0110, 32'h0180_fe20},
    '{OP_SADD,  ELEM_S8,  32'h7f80_40c0, 32'h01ff_40c0},
    '{OP_SADD,  ELEM_S16, 32'h7fff_8000, 32'h0001_ffff},
    '{OP_SADD,  ELEM_U16, 32'hffff_1234, 32'h0001_0001},
    '{OP_SSUB,  ELEM_U8,  32'h0010_ff00, 32'h0111_00ff},
    '{OP_SSUB,  ELEM_S8,  32'h807f_1000, 32'h01ff_0810},
    '{OP_SSUB,  ELEM_S16, 32'h8000_7fff, 32'h0001_ffff},
    '{OP_CMPEQ, ELEM_S16, 32'h1234_5678, 32'h1234_5679},
    '{OP_CMPEQ, ELEM_U8,  32'h1234_5678, 32'h1234_5679},
    '{OP_CMPLT, ELEM_S8,  32'h80ff_0101, 32'h7f01_0180},
    '{OP_CMPLE, ELEM_U16, 32'h8000_1234, 32'h7fff_1234},
    '{OP_MIN,   ELEM_S8,  32'h807f_0510, 32'h7f80_0510},
    '{OP_MIN,   ELEM_U8,  32'h807f_0510, 32'h7f80_0510},
    '{OP_MAX,   ELEM_U16, 32'h8000_0001, 32'h7fff_ffff},
    '{OP_MAX,   ELEM_S16, 32'h8000_0001, 32'h7fff_ffff}
  };

  logic            clk;
  logic            reset;
  logic            enable;
  pext_req_t       req;
  logic [XLEN-1:0] result;
  logic            valid;

  int              errors;
  int              tests;
  int              cycle_count;
  pext_req_t       pend_req;
  logic            pend_en;
  string           pend_name;

  pext_alu UUT (
    .clk_i    (clk),
    .reset_i  (reset),
    .enable_i (enable),
    .req_i    (req),
    .result_o (result),
    .valid_o  (valid)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Watchdog
  initial begin
    cycle_count = 0;
    while (cycle_count < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Run stopped after %0d cycles, the stimulus never finished", CYCLE_LIMIT);
    $display("TEST FAILED");
    $finish;
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  // Compares the outputs with the request issued one edge earlier
  task automatic check_pending();
    logic [XLEN-1:0] exp_result;
    int              fails;
    exp_result = pend_en ? pext_model(pend_req.op, pend_req.elem, pend_req.a, pend_req.b) : '0;
    fails = 0;
    assert (valid === pend_en) else begin
      $display("Mismatch at %0t: valid_o expected %b, actual %b", $time, pend_en, valid);
      fails++;
    end
    assert (result === exp_result) else begin
      $display("Mismatch at %0t: result_o expected %h, actual %h", $time, exp_result, result);
      fails++;
    end
    tests++;
    if (fails != 0) begin
      errors++;
    end
    $display("Test %0d %s: %s", tests, pend_name, (fails == 0) ? "ok" : "error");
  endtask

  task automatic issue(input pext_req_t next_req, input logic next_en);
    pext_op_e   op;
    pext_elem_e elem;
    op   = next_req.op;
    elem = next_req.elem;
    @(posedge clk);
    req    <= next_req;
    enable <= next_en;
    @(negedge clk);
    check_pending();
    pend_req  = next_req;
    pend_en   = next_en;
    pend_name = next_en ? $sformatf("%s %s a=%h b=%h", op.name(), elem.name(),
                                    next_req.a, next_req.b) : "idle";
  endtask

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  initial begin
    pext_req_t rnd;
    int        i;
    void'($urandom(32'hfc3a4bf0));
    // A live request during reset must not reach the outputs
    reset     = 1'b1;
    enable    = 1'b1;
    req       = VEC_TABLE[0];
    errors    = 0;
    tests     = 0;
    pend_req  = '0;
    pend_en   = 1'b0;
    pend_name = "reset";
    repeat (RESET_CYCLES) @(posedge clk);
    reset  <= 1'b0;
    enable <= 1'b0;
    @(negedge clk);
    check_pending();
    // Next edge sees enable low with a nonzero request
    pend_name = "idle";

    for (i = 0; i < NUM_VEC; i++) begin
      issue(VEC_TABLE[i], 1'b1);
    end
    issue(VEC_TABLE[0], 1'b0);

    for (i = 0; i < NUM_RANDOM; i++) begin
      rnd.op   = pext_op_e'($urandom_range(10, 0));
      rnd.elem = pext_elem_e'($urandom_range(3, 0));
      rnd.a    = $urandom;
      rnd.b    = $urandom;
      // Equal or sign-flipped operands now and then
      if ($urandom_range(3, 0) == 0) begin
        rnd.b = rnd.a ^ ($urandom & 32'h8080_8080);
      end
      issue(rnd, 1'b1);
    end
    issue(VEC_TABLE[0], 1'b0);

    $display("%0d tests, %0d passed, %0d failed", tests, tests - errors, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
